//--- Makefile
# Verilator lint, simulation and clean for the image stream frame buffer

VERILATOR  ?= verilator
TOP        ?= img_stream_tb
LINT_TOP   ?= img_stream_top
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) --top-module $(LINT_TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG) || { echo "No pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/img_stream_tb.sv
// Fixed-seed random frames of 2 to 256 words, so the DUT must keep the default 8-bit address width
`timescale 1ns/100ps
`default_nettype none

module img_stream_tb;
    import img_buffer_pkg::*;

    localparam int NUM_FRAMES = 10;
    localparam int MAX_WORDS  = 1 << DEFAULT_ADDR_BITS;

    logic        clk_i = 1'b0;
    logic        reset;
    logic [31:0] in_data_i;
    logic        in_valid_i;
    logic        downstream_stall_i;
    logic [31:0] out_data_o;
    logic        out_valid_o;
    logic        out_last_o;
    logic        upstream_stall_o;
    logic [31:0] checksum_o;
    logic        checksum_valid_o;

    // Reference model, written by the driver only
    logic [31:0] model_q[$];
    logic [31:0] sums[NUM_FRAMES];
    int          lens[NUM_FRAMES];
    int          total_words;
    int          frames_sent;
    logic        plan_ready;
    logic        run_checks;
    logic        run_stalls;
    logic [31:0] data_rng;
    logic [31:0] stall_rng;
    int          drv_errors;

    // Monitor state
    logic        in_frame;
    logic        just_ended;
    logic        csum_due;
    logic        prev_stalled;
    logic [31:0] prev_data;
    logic        prev_last;
    int          mon_frame;
    int          mon_ptr;
    int          word_idx;
    int          frames_done;
    int          mon_errors;

    img_stream_top img_stream_top_inst (
        .clk_i             (clk_i),
        .reset             (reset),
        .in_data_i         (in_data_i),
        .in_valid_i        (in_valid_i),
        .downstream_stall_i(downstream_stall_i),
        .out_data_o        (out_data_o),
        .out_valid_o       (out_valid_o),
        .out_last_o        (out_last_o),
        .upstream_stall_o  (upstream_stall_o),
        .checksum_o        (checksum_o),
        .checksum_valid_o  (checksum_valid_o)
    );

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_word();
        data_rng = xorshift32(data_rng);
        return data_rng;
    endfunction

    // One frame in, then wait for the replay to finish
    task automatic send_frame(input int idx);
        int          n;
        int          r;
        int          gap;
        logic [31:0] word;
        logic [31:0] rnd;
        logic [31:0] sum;
        n = lens[idx];
        rnd = next_word();
        // First frames force a round-up, the rest pick 0 to 3 missing bytes
        r = (idx == 0) ? 3 : ((idx == 1) ? 1 : int'(rnd[1:0]));
        sum = '0;
        frames_sent = frames_sent + 1;
        for (int i = 0; i < n; i++) begin
            rnd = next_word();
            word = (i == 0) ? 32'(4 * n - r) : next_word();
            gap = (rnd[7:6] == 2'b00) ? int'(rnd[1:0]) : 0;
            repeat (gap) begin
                @(posedge clk_i);
                #2;
                in_valid_i = 1'b0;
                in_data_i  = rnd;
            end
            @(posedge clk_i);
            #2;
            in_data_i  = word;
            in_valid_i = 1'b1;
            model_q.push_back(word);
            sum = sum + word;
        end
        sums[idx] = sum;
        @(negedge clk_i);
        assert (!out_valid_o && !upstream_stall_o) else begin
            $display("Fail %0t: frame %0d output rose before its last input word", $time, idx);
            drv_errors++;
        end
        @(posedge clk_i);
        #2;
        in_valid_i = 1'b0;
        @(negedge clk_i);
        assert (out_valid_o && upstream_stall_o) else begin
            $display("Fail %0t: frame %0d output did not rise one cycle after fill", $time, idx);
            drv_errors++;
        end
        // Odd frames push one word into the stalled window, it must be dropped
        if (idx % 2 == 1) begin
            @(posedge clk_i);
            #2;
            in_data_i  = next_word();
            in_valid_i = 1'b1;
            @(negedge clk_i);
            assert (upstream_stall_o) else begin
                $display("Fail %0t: extra word of frame %0d fell outside the stall", $time, idx);
                drv_errors++;
            end
            @(posedge clk_i);
            #2;
            in_valid_i = 1'b0;
        end
        while (upstream_stall_o) begin
            @(negedge clk_i);
        end
    endtask

    task automatic check_cycle();
        logic [31:0] exp_word;
        if (csum_due) begin
            csum_due = 1'b0;
            assert (checksum_valid_o) else begin
                $display("Fail %0t: no checksum pulse after frame %0d", $time, mon_frame);
                mon_errors++;
            end
            assert (checksum_o == sums[mon_frame]) else begin
                $display("Fail %0t: checksum %h, expected %h", $time, checksum_o,
                         sums[mon_frame]);
                mon_errors++;
            end
            $display("frame %0d done: %0d words, checksum %h, failed checks so far %0d",
                     mon_frame, lens[mon_frame], checksum_o, mon_errors + drv_errors);
            mon_frame++;
            frames_done++;
        end else begin
            assert (!checksum_valid_o) else begin
                $display("Fail %0t: checksum_valid_o pulsed outside a frame end", $time);
                mon_errors++;
            end
        end
        if (just_ended) begin
            just_ended = 1'b0;
        end else if (!in_frame && out_valid_o) begin
            if (mon_frame >= frames_sent) begin
                $display("Fail %0t: output valid with no frame sent", $time);
                mon_errors++;
            end else begin
                in_frame     = 1'b1;
                word_idx     = 0;
                prev_stalled = 1'b0;
            end
        end
        assert (out_valid_o == in_frame && upstream_stall_o == in_frame) else begin
            $display("Fail %0t: out_valid_o %b upstream_stall_o %b, expected %b", $time,
                     out_valid_o, upstream_stall_o, in_frame);
            mon_errors++;
        end
        if (in_frame) begin
            if (prev_stalled) begin
                assert (out_data_o == prev_data && out_last_o == prev_last) else begin
                    $display("Fail %0t: output changed under stall", $time);
                    mon_errors++;
                end
            end
            assert (out_last_o == (word_idx == lens[mon_frame] - 1)) else begin
                $display("Fail %0t: out_last_o %b at word %0d of %0d", $time, out_last_o,
                         word_idx, lens[mon_frame]);
                mon_errors++;
            end
            if (!downstream_stall_i) begin
                exp_word = model_q[mon_ptr];
                assert (out_data_o == exp_word) else begin
                    $display("Fail %0t: frame %0d word %0d is %h, expected %h", $time,
                             mon_frame, word_idx, out_data_o, exp_word);
                    mon_errors++;
                end
                mon_ptr++;
                word_idx++;
                if (word_idx == lens[mon_frame]) begin
                    in_frame   = 1'b0;
                    just_ended = 1'b1;
                    csum_due   = 1'b1;
                end
            end
            prev_stalled = downstream_stall_i;
            prev_data    = out_data_o;
            prev_last    = out_last_o;
        end
    endtask

    initial begin
        in_frame    = 1'b0;
        just_ended  = 1'b0;
        csum_due    = 1'b0;
        mon_frame   = 0;
        mon_ptr     = 0;
        frames_done = 0;
        mon_errors  = 0;
        forever begin
            @(negedge clk_i);
            if (run_checks) begin
                check_cycle();
            end
        end
    end

    // Random downstream stalls, about one cycle in three
    initial begin
        downstream_stall_i = 1'b0;
        stall_rng = 32'h25f1_3ffd ^ 32'h9e37_79b9;
        forever begin
            @(posedge clk_i);
            #2;
            stall_rng = xorshift32(stall_rng);
            downstream_stall_i = run_stalls && (stall_rng[3:0] < 4'd5);
        end
    end

    initial begin
        wait (plan_ready);
        repeat (40 * total_words + 500) @(posedge clk_i);
        $display("Watchdog: the run hung with %0d of %0d frames finished, buffer in %s",
                 frames_done, NUM_FRAMES, img_stream_top_inst.img_buffer_inst.state_q.name());
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        in_data_i   = '0;
        in_valid_i  = 1'b0;
        run_checks  = 1'b0;
        run_stalls  = 1'b0;
        frames_sent = 0;
        drv_errors  = 0;
        total_words = 0;
        data_rng    = 32'h25f1_3ffd;
        // Shortest and longest frames first, then random lengths
        for (int i = 0; i < NUM_FRAMES; i++) begin
            lens[i] = (i == 0) ? 2 : ((i == 1) ? MAX_WORDS : 2 + int'(next_word() % 32'd255));
            total_words = total_words + lens[i];
        end
        plan_ready = 1'b1;
        repeat (4) @(posedge clk_i);
        #2;
        reset = 1'b0;
        @(negedge clk_i);
        assert (!out_valid_o && !upstream_stall_o && !checksum_valid_o) else begin
            $display("Fail %0t: outputs not idle after reset", $time);
            drv_errors++;
        end
        $display("reset test done, failed checks so far %0d", drv_errors);
        run_checks = 1'b1;
        run_stalls = 1'b1;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            send_frame(i);
        end
        wait (frames_done == NUM_FRAMES);
        repeat (4) @(negedge clk_i);
        $display("tests run %0d, frames %0d of %0d, failed checks %0d", frames_done + 1,
                 frames_done, NUM_FRAMES, drv_errors + mon_errors);
        if (drv_errors + mon_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
logic/img_buffer_pkg.sv
logic/frame_ram.sv
logic/img_buffer.sv
logic/frame_checksum.sv
logic/img_stream_top.sv
dv/img_stream_tb.sv

//--- logic/frame_checksum.sv
// Additive 32-bit frame checksum, sums words accepted while valid is high and stall is low
`timescale 1ns/100ps
`default_nettype none

module frame_checksum (
    input  wire                                 clk_i,
    input  wire                                 reset,
    input  wire  [img_buffer_pkg::WORD_BITS-1:0] word_i,
    input  wire                                 valid_i,
    input  wire                                 last_i,
    input  wire                                 stall_i,
    output logic [img_buffer_pkg::WORD_BITS-1:0] checksum_o,
    output logic                                checksum_valid_o
);
    import img_buffer_pkg::*;

    logic [WORD_BITS-1:0] sum_q;
    logic [WORD_BITS-1:0] sum_next;
    logic                 accept;

    assign accept   = valid_i && !stall_i;
    // Wraps modulo 2**32
    assign sum_next = sum_q + word_i;

    always_ff @(posedge clk_i) begin
        if (reset) begin
            sum_q            <= '0;
            checksum_valid_o <= 1'b0;
        end else begin
            checksum_valid_o <= accept && last_i;
            if (accept) begin
                // Restart for the next frame
                sum_q <= last_i ? '0 : sum_next;
            end
        end
    end

    // Finished sum, qualified by checksum_valid_o
    always_ff @(posedge clk_i) begin
        if (accept && last_i) begin
            checksum_o <= sum_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/frame_ram.sv
// Single-port RAM, read returns the old word when writing the same address; no reset on contents
`timescale 1ns/100ps
`default_nettype none

module frame_ram #(
    parameter int ADDR_BITS = img_buffer_pkg::DEFAULT_ADDR_BITS
) (
    input  wire                                 clk_i,
    input  wire  [ADDR_BITS-1:0]                addr_i,
    input  wire  [img_buffer_pkg::WORD_BITS-1:0] data_i,
    input  wire                                 we_i,
    output logic [img_buffer_pkg::WORD_BITS-1:0] data_o
);
    import img_buffer_pkg::*;

    localparam int DEPTH = 1 << ADDR_BITS;

    logic [WORD_BITS-1:0] mem [DEPTH];

    // Write on the edge, addressed word lands in the read register every cycle
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[addr_i] <= data_i;
        end
        data_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

//--- logic/img_buffer.sv
// Store-and-forward frame buffer; frames must be 2 to 2**ADDR_BITS words, input is dropped in SEND
`timescale 1ns/100ps
`default_nettype none

module img_buffer #(
    parameter int ADDR_BITS = img_buffer_pkg::DEFAULT_ADDR_BITS
) (
    input  wire                                 clk_i,
    input  wire                                 reset,
    input  wire  [img_buffer_pkg::WORD_BITS-1:0] in_data_i,
    input  wire                                 in_valid_i,
    input  wire                                 downstream_stall_i,
    output logic [img_buffer_pkg::WORD_BITS-1:0] out_data_o,
    output logic                                out_valid_o,
    output logic                                out_last_o,
    output logic                                upstream_stall_o,
    output logic [ADDR_BITS-1:0]                ram_addr_o,
    output logic [img_buffer_pkg::WORD_BITS-1:0] ram_wdata_o,
    output logic                                ram_we_o,
    input  wire  [img_buffer_pkg::WORD_BITS-1:0] ram_rdata_i
);
    import img_buffer_pkg::*;

    // One extra bit so a full-depth frame length fits
    localparam int CNT_BITS = ADDR_BITS + 1;

    buf_state_e           state_q;
    logic [CNT_BITS-1:0]  count_q;
    logic [CNT_BITS-1:0]  len_q;
    logic [WORD_BITS-1:0] data_q;
    logic [WORD_BITS-1:0] second_q;

    logic [CNT_BITS-1:0]  hdr_len;
    logic [CNT_BITS-1:0]  rd_index;
    logic                 sending;
    logic                 accept;
    logic                 last_word;

    // Byte count rounded up to whole words
    assign hdr_len = in_data_i[CNT_BITS+1:2] + {{(CNT_BITS-1){1'b0}}, |in_data_i[1:0]};

    assign sending   = (state_q == SEND);
    assign accept    = sending && !downstream_stall_i;
    assign last_word = (count_q == len_q - CNT_BITS'(1));

    assign out_data_o       = data_q;
    assign out_valid_o      = sending;
    assign out_last_o       = sending && last_word;
    assign upstream_stall_o = sending;

    // Read address sits one past the word that will be shown next cycle
    assign rd_index = count_q + (accept ? CNT_BITS'(2) : CNT_BITS'(1));

    // count_q is zero in WAIT_HDR, so the header goes to address 0
    assign ram_addr_o  = sending ? rd_index[ADDR_BITS-1:0] : count_q[ADDR_BITS-1:0];
    assign ram_wdata_o = in_data_i;
    assign ram_we_o    = in_valid_i && !sending;

    always_ff @(posedge clk_i) begin
        if (reset) begin
            state_q <= WAIT_HDR;
            count_q <= '0;
            len_q   <= '0;
        end else begin
            case (state_q)
                WAIT_HDR: begin
                    if (in_valid_i) begin
                        len_q   <= hdr_len;
                        count_q <= CNT_BITS'(1);
                        state_q <= FILL;
                    end
                end
                FILL: begin
                    if (in_valid_i) begin
                        if (last_word) begin
                            count_q <= '0;
                            state_q <= SEND;
                        end else begin
                            count_q <= count_q + CNT_BITS'(1);
                        end
                    end
                end
                SEND: begin
                    if (accept) begin
                        if (last_word) begin
                            count_q <= '0;
                            len_q   <= '0;
                            state_q <= WAIT_HDR;
                        end else begin
                            count_q <= count_q + CNT_BITS'(1);
                        end
                    end
                end
                default: state_q <= WAIT_HDR;
            endcase
        end
    end

    // The RAM is still busy writing when SEND starts, so word 1 is kept aside
    always_ff @(posedge clk_i) begin
        if (state_q == FILL && in_valid_i && count_q == CNT_BITS'(1)) begin
            second_q <= in_data_i;
        end
    end

    // Header goes straight to the output, later words come from the RAM
    always_ff @(posedge clk_i) begin
        if (state_q == WAIT_HDR && in_valid_i) begin
            data_q <= in_data_i;
        end else if (accept && !last_word) begin
            data_q <= (count_q == '0) ? second_q : ram_rdata_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/img_buffer_pkg.sv
// Shared constants and FSM states; stream words are fixed at 32 bits by the header format
`default_nettype none

package img_buffer_pkg;

    // Stream word and RAM entry width
    localparam int WORD_BITS = 32;

    // 256 words of frame storage by default
    localparam int DEFAULT_ADDR_BITS = 8;

    // Buffer controller states
    typedef enum logic [1:0] {
        WAIT_HDR,
        FILL,
        SEND
    } buf_state_e;

endpackage

`default_nettype wire

//--- logic/img_stream_top.sv
// Frame buffer top; source must honour upstream_stall_o, words sent while it is high are lost
`timescale 1ns/100ps
`default_nettype none

module img_stream_top #(
    parameter int ADDR_BITS = img_buffer_pkg::DEFAULT_ADDR_BITS
) (
    input  wire                                 clk_i,
    input  wire                                 reset,
    input  wire  [img_buffer_pkg::WORD_BITS-1:0] in_data_i,
    input  wire                                 in_valid_i,
    input  wire                                 downstream_stall_i,
    output logic [img_buffer_pkg::WORD_BITS-1:0] out_data_o,
    output logic                                out_valid_o,
    output logic                                out_last_o,
    output logic                                upstream_stall_o,
    output logic [img_buffer_pkg::WORD_BITS-1:0] checksum_o,
    output logic                                checksum_valid_o
);
    import img_buffer_pkg::*;

    logic [ADDR_BITS-1:0] ram_addr;
    logic [WORD_BITS-1:0] ram_wdata;
    logic                 ram_we;
    logic [WORD_BITS-1:0] ram_rdata;

    img_buffer #(
        .ADDR_BITS(ADDR_BITS)
    ) img_buffer_inst (
        .clk_i             (clk_i),
        .reset             (reset),
        .in_data_i         (in_data_i),
        .in_valid_i        (in_valid_i),
        .downstream_stall_i(downstream_stall_i),
        .out_data_o        (out_data_o),
        .out_valid_o       (out_valid_o),
        .out_last_o        (out_last_o),
        .upstream_stall_o  (upstream_stall_o),
        .ram_addr_o        (ram_addr),
        .ram_wdata_o       (ram_wdata),
        .ram_we_o          (ram_we),
        .ram_rdata_i       (ram_rdata)
    );

    frame_ram #(
        .ADDR_BITS(ADDR_BITS)
    ) frame_ram_inst (
        .clk_i (clk_i),
        .addr_i(ram_addr),
        .data_i(ram_wdata),
        .we_i  (ram_we),
        .data_o(ram_rdata)
    );

    // Watches the replayed stream, same acceptance rule as downstream
    frame_checksum frame_checksum_inst (
        .clk_i           (clk_i),
        .reset           (reset),
        .word_i          (out_data_o),
        .valid_i         (out_valid_o),
        .last_i          (out_last_o),
        .stall_i         (downstream_stall_i),
        .checksum_o      (checksum_o),
        .checksum_valid_o(checksum_valid_o)
    );

endmodule

`default_nettype wire
